/* bench/mac_array_tb.sv */
`timescale 1ns/1ps
`include "mac_defs.svh"

module mac_array_tb;

    localparam int MAX_LINES = 64;
    localparam int FIELDS    = 5 + 4 * `NUM_LANES;  // Header, three operands and result per lane
    localparam int RES_COL   = 5 + 3 * `NUM_LANES;
    localparam int MAX_TESTS = 8;
    localparam int DRAIN     = `LANE_LATENCY + 4;

    logic                clk;
    logic                reset;
    logic                enable;
    logic                in_valid;
    warp_pkg::warp_req_t in_req;
    logic                out_valid;
    warp_pkg::warp_rsp_t out_rsp;

    logic [`DATA_WIDTH-1:0] stim [MAX_LINES*FIELDS];

    warp_pkg::warp_rsp_t exp_q[$];
    int                  left_q[$];  // Enabled edges until the response is due
    int                  tid_q[$];

    int num_lines   = 0;
    int lines_done  = 0;
    int cycle_count = 0;
    int cycle_limit = 0;
    int err_count   = 0;
    int rsp_count   = 0;
    int last_line    [MAX_TESTS];
    int test_err     [MAX_TESTS];
    int test_rsp     [MAX_TESTS];
    int test_pending [MAX_TESTS];
    bit reported     [MAX_TESTS];

    mac_array_top DUT (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_rsp   (out_rsp)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Run stopped after %0d cycles without finishing", cycle_count);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic int count_lines();
        for (int i = 0; i < MAX_LINES; i++) begin
            if ($isunknown(stim[i*FIELDS]) || stim[i*FIELDS] == '0) begin
                return i;
            end
        end
        return MAX_LINES;
    endfunction

    function automatic logic [`DATA_WIDTH-1:0] field_at(input int line, input int col);
        return stim[line*FIELDS + col];
    endfunction

    function automatic warp_pkg::warp_req_t build_req(input int line);
        warp_pkg::warp_req_t    req;
        logic [`DATA_WIDTH-1:0] word;
        word     = field_at(line, 3);
        req.tag  = word[`TAG_WIDTH-1:0];
        word     = field_at(line, 4);
        req.mask = word[`NUM_LANES-1:0];
        for (int i = 0; i < `NUM_LANES; i++) begin
            req.ops[i].a = field_at(line, 5 + 3*i);
            req.ops[i].b = field_at(line, 6 + 3*i);
            req.ops[i].c = field_at(line, 7 + 3*i);
        end
        return req;
    endfunction

    function automatic warp_pkg::warp_rsp_t build_rsp(input int line);
        warp_pkg::warp_rsp_t    rsp;
        logic [`DATA_WIDTH-1:0] word;
        word     = field_at(line, 3);
        rsp.tag  = word[`TAG_WIDTH-1:0];
        word     = field_at(line, 4);
        rsp.mask = word[`NUM_LANES-1:0];
        for (int i = 0; i < `NUM_LANES; i++) begin
            rsp.value[i] = field_at(line, RES_COL + i);
        end
        return rsp;
    endfunction

    function automatic void note_error(input int tid);
        err_count    = err_count + 1;
        test_err[tid] = test_err[tid] + 1;
    endfunction

    task automatic check_rsp(input warp_pkg::warp_rsp_t got, input warp_pkg::warp_rsp_t exp,
                             input int tid);
        int i;
        if (got.tag !== exp.tag) begin
            $display("Error: out_rsp.tag expected 0x%h got 0x%h", exp.tag, got.tag);
            note_error(tid);
        end
        if (got.mask !== exp.mask) begin
            $display("Error: out_rsp.mask expected 0x%h got 0x%h", exp.mask, got.mask);
            note_error(tid);
        end
        for (i = 0; i < `NUM_LANES; i++) begin
            if (got.value[i] !== exp.value[i]) begin
                $display("Error: out_rsp.value[%0d] expected 0x%h got 0x%h (tag 0x%h)",
                         i, exp.value[i], got.value[i], exp.tag);
                note_error(tid);
            end
        end
    endtask

    task automatic check_idle(input logic got, input int tid);
        if (got !== 1'b0) begin
            $display("Error: out_valid expected 0x0 got 0x%h", got);
            note_error(tid);
        end
    endtask

    task automatic check_outputs(input int tid);
        int owner;
        if (left_q.size() > 0 && left_q[0] == 0) begin
            owner = tid_q[0];
            if (out_valid === 1'b1) begin
                check_rsp(out_rsp, exp_q[0], owner);
                rsp_count      = rsp_count + 1;
                test_rsp[owner] = test_rsp[owner] + 1;
            end else begin
                $display("Response for tag 0x%h did not appear when it was due", exp_q[0].tag);
                note_error(owner);
            end
            exp_q.delete(0);
            left_q.delete(0);
            tid_q.delete(0);
            test_pending[owner] = test_pending[owner] - 1;
        end else if (out_valid === 1'b1 && exp_q.size() == 0) begin
            $display("A response appeared while no request was outstanding");
            note_error(tid);
        end else begin
            check_idle(out_valid, tid);
        end
    endtask

    task automatic run_cycle(input logic en, input logic vld, input int tid,
                             input warp_pkg::warp_req_t req, input warp_pkg::warp_rsp_t exp);
        int i;
        @(posedge clk);
        if (enable) begin  // Value the DUT samples on this edge
            for (i = 0; i < left_q.size(); i++) begin
                if (left_q[i] > 0) begin
                    left_q[i] = left_q[i] - 1;
                end
            end
        end
        reset    <= 1'b0;
        enable   <= en;
        in_valid <= vld;
        in_req   <= req;
        if (en && vld) begin
            exp_q.push_back(exp);
            left_q.push_back(`LANE_LATENCY + 2);  // Acceptance edge, then LANE_LATENCY+1 more
            tid_q.push_back(tid);
            test_pending[tid] = test_pending[tid] + 1;
        end
        @(negedge clk);
        check_outputs(tid);
    endtask

    function automatic void print_test(input int t);
        if (test_err[t] == 0 && test_pending[t] == 0) begin
            $display("Test %0d passed: %0d responses checked", t, test_rsp[t]);
        end else begin
            $display("Test %0d failed: %0d responses checked, %0d errors, %0d missing",
                     t, test_rsp[t], test_err[t], test_pending[t]);
        end
        reported[t] = 1'b1;
    endfunction

    function automatic void report_finished();
        for (int t = 1; t < MAX_TESTS; t++) begin
            if (last_line[t] >= 0 && !reported[t] && lines_done > last_line[t]
                && test_pending[t] == 0) begin
                print_test(t);
            end
        end
    endfunction

    initial begin
        int                     line;
        int                     tid;
        int                     last_tid;
        int                     num_tests;
        logic [`DATA_WIDTH-1:0] en_word;
        logic [`DATA_WIDTH-1:0] vld_word;
        reset    = 1'b1;
        enable   = 1'b0;
        in_valid = 1'b0;
        in_req   = '0;
        last_tid = 0;
        for (tid = 0; tid < MAX_TESTS; tid++) begin
            last_line[tid]    = -1;
            test_err[tid]     = 0;
            test_rsp[tid]     = 0;
            test_pending[tid] = 0;
            reported[tid]     = 1'b0;
        end
        $readmemh("bench/mac_input.txt", stim);
        num_lines   = count_lines();
        cycle_limit = num_lines + `LANE_LATENCY + 20;
        if (num_lines == 0) begin
            $display("Stimulus file holds no usable lines");
            err_count = err_count + 1;
        end
        for (line = 0; line < num_lines; line++) begin
            tid = field_at(line, 0);
            if (tid < 1 || tid >= MAX_TESTS) begin
                $display("Line %0d names test %0d, which is out of range", line, tid);
                err_count = err_count + 1;
            end else begin
                last_line[tid] = line;
            end
        end

        // Eighth reset edge comes with the first stimulus line
        repeat (7) begin
            @(posedge clk);
            @(negedge clk);
            check_idle(out_valid, 0);
        end

        for (line = 0; line < num_lines; line++) begin
            tid = field_at(line, 0);
            if (tid < 1 || tid >= MAX_TESTS) begin
                tid = 0;
            end
            en_word  = field_at(line, 1);
            vld_word = field_at(line, 2);
            run_cycle(en_word[0], vld_word[0], tid, build_req(line), build_rsp(line));
            last_tid   = tid;
            lines_done = line + 1;
            report_finished();
        end

        repeat (DRAIN) begin
            run_cycle(1'b1, 1'b0, last_tid, '0, '0);
            report_finished();
        end

        if (exp_q.size() != 0) begin
            $display("%0d expected responses never arrived", exp_q.size());
            err_count = err_count + exp_q.size();
        end
        num_tests = 0;
        for (tid = 1; tid < MAX_TESTS; tid++) begin
            if (last_line[tid] >= 0) begin
                num_tests = num_tests + 1;
                if (!reported[tid]) begin
                    print_test(tid);
                end
            end
        end
        $display("Summary: %0d tests, %0d responses checked, %0d errors",
                 num_tests, rsp_count, err_count);
        if (err_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* bench/mac_input.txt */
// test enable in_valid tag mask, then a b c for lanes 0..3, then expected results 0..3
// Expected results are a*b+c mod 2^16 for active lanes and zero for masked lanes
// Test 1: idle after reset
1 1 0 0 0  0000 0000 0000  0000 0000 0000  0000 0000 0000  0000 0000 0000  0000 0000 0000 0000
1 1 0 0 0  0000 0000 0000  0000 0000 0000  0000 0000 0000  0000 0000 0000  0000 0000 0000 0000
1 1 0 0 0  0000 0000 0000  0000 0000 0000  0000 0000 0000  0000 0000 0000  0000 0000 0000 0000
// Test 2: full mask, exact latency
2 1 1 1 f  0003 0004 0005  0010 0010 0001  0100 0002 0020  00ff 00ff 0000  0011 0101 0220 fe01
2 1 0 0 0  0000 0000 0000  0000 0000 0000  0000 0000 0000  0000 0000 0000  0000 0000 0000 0000
2 1 0 0 0  0000 0000 0000  0000 0000 0000  0000 0000 0000  0000 0000 0000  0000 0000 0000 0000
2 1 0 0 0  0000 0000 0000  0000 0000 0000  0000 0000 0000  0000 0000 0000  0000 0000 0000 0000
2 1 0 0 0  0000 0000 0000  0000 0000 0000  0000 0000 0000  0000 0000 0000  0000 0000 0000 0000
2 1 0 0 0  0000 0000 0000  0000 0000 0000  0000 0000 0000  0000 0000 0000  0000 0000 0000 0000
2 1 0 0 0  0000 0000 0000  0000 0000 0000  0000 0000 0000  0000 0000 0000  0000 0000 0000 0000
// Test 3: partial and empty masks
3 1 1 2 5  0002 0003 0004  1111 2222 3333  0007 0008 0009  ffff ffff ffff  000a 0000 0041 0000
3 1 1 3 a  0005 0005 0005  000a 000a 000a  0001 0001 0001  0020 0030 0000  0000 006e 0000 0600
3 1 1 4 0  0001 0002 0003  0001 0002 0003  0001 0002 0003  0001 0002 0003  0000 0000 0000 0000
3 1 0 0 0  0000 0000 0000  0000 0000 0000  0000 0000 0000  0000 0000 0000  0000 0000 0000 0000
3 1 0 0 0  0000 0000 0000  0000 0000 0000  0000 0000 0000  0000 0000 0000  0000 0000 0000 0000
// Test 4: back-to-back requests
4 1 1 5 f  0001 0001 0001  0002 0002 0002  0003 0003 0003  0004 0004 0004  0002 0006 000c 0014
4 1 1 6 f  0010 0001 0000  0000 1234 5678  0100 0100 0000  00ab 0001 0100  0010 5678 0000 01ab
4 1 1 7 f  000c 000d 000e  0011 0011 0011  0080 0002 0001  0005 0007 0009  00aa 0132 0101 002c
4 1 1 8 f  1000 0010 0000  0fff 0001 0001  0002 4000 0003  0006 0006 0006  0000 1000 8003 002a
4 1 0 0 0  0000 0000 0000  0000 0000 0000  0000 0000 0000  0000 0000 0000  0000 0000 0000 0000
4 1 0 0 0  0000 0000 0000  0000 0000 0000  0000 0000 0000  0000 0000 0000  0000 0000 0000 0000
// Test 5: enable low mid-flight, the in_valid pulse while disabled is ignored
5 1 1 9 f  0002 0005 0001  0007 0007 0007  0040 0040 0000  0003 0100 0010  000b 0038 1000 0310
5 1 1 a 3  0009 0009 0000  0010 0010 0010  0001 0001 0001  0001 0001 0001  0051 0110 0000 0000
5 0 0 0 0  0000 0000 0000  0000 0000 0000  0000 0000 0000  0000 0000 0000  0000 0000 0000 0000
5 0 1 b f  0001 0001 0001  0001 0001 0001  0001 0001 0001  0001 0001 0001  0002 0002 0002 0002
5 0 0 0 0  0000 0000 0000  0000 0000 0000  0000 0000 0000  0000 0000 0000  0000 0000 0000 0000
5 1 0 0 0  0000 0000 0000  0000 0000 0000  0000 0000 0000  0000 0000 0000  0000 0000 0000 0000
5 1 0 0 0  0000 0000 0000  0000 0000 0000  0000 0000 0000  0000 0000 0000  0000 0000 0000 0000
// Test 6: operands near 0xffff
6 1 1 c f  ffff ffff ffff  ffff 0002 0003  0100 0100 ffff  fffe fffd 0004  0000 0001 ffff 000a
6 1 1 d f  0000 ffff ffff  ffff 0001 0001  7fff 0003 0000  1234 0010 fedc  ffff 0000 7ffd 221c

/* design/lane_dispatch.sv */
`timescale 1ns/1ps
`include "mac_defs.svh"

module lane_dispatch (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  enable,
    input  logic                                  in_valid,
    input  warp_pkg::warp_req_t                   in_req,
    output lane_pkg::lane_op_t [`NUM_LANES-1:0]   lane_ops,
    output warp_pkg::warp_meta_t                  meta
);

    logic                  meta_valid_q;
    logic [`NUM_LANES-1:0] lane_valid_q;
    warp_pkg::warp_req_t   req_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            meta_valid_q <= 1'b0;
            lane_valid_q <= '0;
        end else if (enable) begin
            meta_valid_q <= in_valid;  // Empty mask still gets a response
            lane_valid_q <= {`NUM_LANES{in_valid}} & in_req.mask;
        end
    end

    always_ff @(posedge clk) begin
        if (enable && in_valid) begin
            req_q <= in_req;
        end
    end

    // Split the registered request into lane operands
    always_comb begin
        meta.valid = meta_valid_q;
        meta.tag   = req_q.tag;
        meta.mask  = req_q.mask;
        for (int i = 0; i < `NUM_LANES; i++) begin
            lane_ops[i].valid = lane_valid_q[i];
            lane_ops[i].a     = req_q.ops[i].a;
            lane_ops[i].b     = req_q.ops[i].b;
            lane_ops[i].c     = req_q.ops[i].c;
        end
    end

endmodule

/* design/lane_pkg.sv */
`include "mac_defs.svh"

package lane_pkg;

    typedef struct packed {
        logic                   valid;  // Lane takes part in this request
        logic [`DATA_WIDTH-1:0] a;
        logic [`DATA_WIDTH-1:0] b;
        logic [`DATA_WIDTH-1:0] c;
    } lane_op_t;

    typedef struct packed {
        logic                   valid;
        logic [`DATA_WIDTH-1:0] value;  // a*b+c mod 2^DATA_WIDTH
    } lane_res_t;

endpackage

/* design/mac_array_top.sv */
`timescale 1ns/1ps
`include "mac_defs.svh"

module mac_array_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                enable,
    input  logic                in_valid,
    input  warp_pkg::warp_req_t in_req,
    output logic                out_valid,
    output warp_pkg::warp_rsp_t out_rsp
);

    lane_pkg::lane_op_t  [`NUM_LANES-1:0] lane_ops;
    lane_pkg::lane_res_t [`NUM_LANES-1:0] lane_res;
    warp_pkg::warp_meta_t                 meta;

    lane_dispatch dispatch (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .in_valid (in_valid),
        .in_req   (in_req),
        .lane_ops (lane_ops),
        .meta     (meta)
    );

    for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
        mac_lane lane (
            .clk    (clk),
            .reset  (reset),
            .enable (enable),
            .op     (lane_ops[i]),
            .res    (lane_res[i])
        );
    end

    result_collect collect (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable),
        .meta      (meta),
        .lane_res  (lane_res),
        .out_valid (out_valid),
        .out_rsp   (out_rsp)
    );

endmodule

/* design/mac_defs.svh */
`ifndef MAC_DEFS_SVH
`define MAC_DEFS_SVH

// SIMD width of the unit
`define NUM_LANES 4

// Operand and result width
`define DATA_WIDTH 16

// Warp identifier carried through the pipeline
`define TAG_WIDTH 4

// Enabled cycles from lane operand to lane result, at least 2
`define LANE_LATENCY 4

`endif

/* design/mac_lane.sv */
`timescale 1ns/1ps
`include "mac_defs.svh"

module mac_lane (
    input  logic                clk,
    input  logic                reset,
    input  logic                enable,
    input  lane_pkg::lane_op_t  op,
    output lane_pkg::lane_res_t res
);

    logic [`DATA_WIDTH-1:0] prod_sum;
    logic                   sum_valid_q;
    logic [`DATA_WIDTH-1:0] sum_value_q;
    lane_pkg::lane_res_t    stage_in;

    // Context width is DATA_WIDTH so the carry out is dropped
    assign prod_sum = op.a * op.b + op.c;

    always_ff @(posedge clk) begin
        if (reset) begin
            sum_valid_q <= 1'b0;
        end else if (enable) begin
            sum_valid_q <= op.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            sum_value_q <= prod_sum;
        end
    end

    assign stage_in = '{valid: sum_valid_q, value: sum_value_q};

    // Remaining LANE_LATENCY-1 cycles of the lane
    stage_shift_reg #(
        .PAYLOAD_T (lane_pkg::lane_res_t),
        .DEPTH     (`LANE_LATENCY - 1),
        .RESET_W   (1)
    ) res_delay (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .data_in  (stage_in),
        .data_out (res)
    );

endmodule

/* design/result_collect.sv */
`timescale 1ns/1ps
`include "mac_defs.svh"

module result_collect (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 enable,
    input  warp_pkg::warp_meta_t                 meta,
    input  lane_pkg::lane_res_t [`NUM_LANES-1:0] lane_res,
    output logic                                 out_valid,
    output warp_pkg::warp_rsp_t                  out_rsp
);

    warp_pkg::warp_meta_t meta_tail;
    warp_pkg::warp_rsp_t  rsp_next;

    // Same depth as a lane so metadata meets its results
    stage_shift_reg #(
        .PAYLOAD_T (warp_pkg::warp_meta_t),
        .DEPTH     (`LANE_LATENCY),
        .RESET_W   (1)
    ) meta_delay (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .data_in  (meta),
        .data_out (meta_tail)
    );

    always_comb begin
        rsp_next.tag  = meta_tail.tag;
        rsp_next.mask = meta_tail.mask;
        for (int i = 0; i < `NUM_LANES; i++) begin
            rsp_next.value[i] = lane_res[i].valid ? lane_res[i].value : '0;
        end
    end

    // Tail only moves on enabled cycles, so gate the strobe with enable
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= meta_tail.valid & enable;
        end
    end

    always_ff @(posedge clk) begin
        out_rsp <= rsp_next;
    end

    for (genvar i = 0; i < `NUM_LANES; i++) begin : g_align
        lane_align_a: assert property (@(posedge clk) disable iff (reset)
            lane_res[i].valid == (meta_tail.valid && meta_tail.mask[i]))
            else $error("result_collect: lane %0d out of step with metadata", i);
    end

endmodule

/* design/stage_shift_reg.sv */
`timescale 1ns/1ps

module stage_shift_reg #(
    parameter type PAYLOAD_T = logic,
    parameter int  DEPTH     = 1,
    parameter int  RESET_W   = 1
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     enable,
    input  PAYLOAD_T data_in,
    output PAYLOAD_T data_out
);

    localparam int DATA_W = $bits(PAYLOAD_T);
    localparam int KEEP_W = DATA_W - RESET_W;  // Bits without reset

    logic [DATA_W-1:0] head;
    logic [DATA_W-1:0] tail;

    if (DEPTH < 1 || RESET_W < 0 || RESET_W > DATA_W) begin : g_bad_param
        $error("stage_shift_reg: bad DEPTH %0d or RESET_W %0d", DEPTH, RESET_W);
    end

    assign head = data_in;

    // Valid bits live at the top of every payload struct
    if (RESET_W > 0) begin : g_rst
        logic [RESET_W-1:0] rst_q [DEPTH];

        always_ff @(posedge clk) begin
            if (reset) begin
                for (int i = 0; i < DEPTH; i++) begin
                    rst_q[i] <= '0;
                end
            end else if (enable) begin
                rst_q[0] <= head[DATA_W-1 -: RESET_W];
                for (int i = 1; i < DEPTH; i++) begin
                    rst_q[i] <= rst_q[i-1];
                end
            end
        end

        assign tail[DATA_W-1 -: RESET_W] = rst_q[DEPTH-1];

        valid_known_a: assert property (@(posedge clk) disable iff (reset)
            !$isunknown(tail[DATA_W-1]))
            else $error("stage_shift_reg: output valid bit is unknown");
    end

    // Payload stages, free to map onto plain flops or RAM
    if (KEEP_W > 0) begin : g_keep
        logic [KEEP_W-1:0] keep_q [DEPTH];

        always_ff @(posedge clk) begin
            if (enable) begin
                keep_q[0] <= head[KEEP_W-1:0];
                for (int i = 1; i < DEPTH; i++) begin
                    keep_q[i] <= keep_q[i-1];
                end
            end
        end

        assign tail[KEEP_W-1:0] = keep_q[DEPTH-1];
    end

    assign data_out = tail;

endmodule

/* design/warp_pkg.sv */
`include "mac_defs.svh"

package warp_pkg;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] a;
        logic [`DATA_WIDTH-1:0] b;
        logic [`DATA_WIDTH-1:0] c;
    } operands_t;

    typedef struct packed {
        logic [`TAG_WIDTH-1:0]      tag;
        logic [`NUM_LANES-1:0]      mask;  // One bit per active lane
        operands_t [`NUM_LANES-1:0] ops;
    } warp_req_t;

    // Travels beside the lanes so the collector knows what it waits for
    typedef struct packed {
        logic                  valid;
        logic [`TAG_WIDTH-1:0] tag;
        logic [`NUM_LANES-1:0] mask;
    } warp_meta_t;

    typedef struct packed {
        logic [`TAG_WIDTH-1:0]                   tag;
        logic [`NUM_LANES-1:0]                   mask;
        logic [`NUM_LANES-1:0][`DATA_WIDTH-1:0]  value;  // Zero for masked lanes
    } warp_rsp_t;

endpackage

/* src.f */
+incdir+design
design/lane_pkg.sv
design/warp_pkg.sv
design/stage_shift_reg.sv
design/mac_lane.sv
design/lane_dispatch.sv
design/result_collect.sv
design/mac_array_top.sv
bench/mac_array_tb.sv
